//--- design/rvInstrPkg.sv
package rvInstrPkg;

    // Architectural word and register index
    typedef logic [31:0] tWord;
    typedef logic [4:0]  tRegIdx;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        BRANCH = 7'b1100011,
        SYSTEM = 7'b1110011
    } tOpcode;

    // ALU operations after decode
    typedef enum logic [2:0] {
        ADD,
        SUB,
        XOR,
        SLT,
        SLTU,
        SLL,
        SRL,
        SRA
    } tAluOp;

    // funct3 values for OP and OP_IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;

    // funct3 values for BRANCH
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;

    // funct7 forms, ALT selects SUB and SRA
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    // Full EBREAK encoding
    localparam tWord EBREAK_INSTR = 32'h0010_0073;

    // ADDI x30, x0, 0x666
    // Pads unused slots of a line, harmless if ever executed
    localparam tWord FILLER_INSTR = 32'h6660_0F13;

    // One retired instruction as seen at the top
    typedef struct packed {
        tRegIdx rd;
        tWord   data;
        tWord   pc;
        logic   wen;
    } tRetire;

endpackage

//--- design/memPkg.sv
package memPkg;

    // Line geometry, 16 words of 4 bytes
    localparam int CL_WORDS = 16;
    localparam int L2_LINES = 8;

    // Bit positions of word and line index in a byte address
    localparam int WORD_IDX_LSB = 2;
    localparam int LINE_IDX_LSB = WORD_IDX_LSB + $clog2(CL_WORDS);

    typedef logic [$clog2(L2_LINES)-1:0] tLineAddr;

    // Word 0 sits in the low bits
    typedef struct packed {
        rvInstrPkg::tWord [CL_WORDS-1:0] w;
    } tCacheLine;

    // Whole-line write into L2
    typedef struct packed {
        tLineAddr  addr;
        tCacheLine line;
    } tLineWrite;

    // Every slot holds the filler instruction
    localparam tCacheLine FILLER_LINE = tCacheLine'({CL_WORDS{rvInstrPkg::FILLER_INSTR}});

endpackage

//--- design/l2Mem.sv
module l2Mem (
    input  logic              clk,
    input  logic              rstN,
    input  logic              lineWrValid,
    input  memPkg::tLineWrite lineWr,
    input  logic              lineRdValid,
    input  memPkg::tLineAddr  lineRdAddr,
    output memPkg::tCacheLine lineRdData
);
    import memPkg::*;

    // Line-wide storage
    tCacheLine lines [L2_LINES];

    // Unwritten lines must read back as filler
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < L2_LINES; i++) begin
                lines[i] <= FILLER_LINE;
            end
        end else if (lineWrValid) begin
            // Whole line at once
            lines[lineWr.addr] <= lineWr.line;
        end
    end

    // Registered read port
    // Data shows up the cycle after the request
    always_ff @(posedge clk) begin
        if (lineRdValid) begin
            lineRdData <= lines[lineRdAddr];
        end
    end

endmodule

//--- design/preload.sv
module preload (
    input  logic              clk,
    input  logic              rstN,
    input  logic              loadValid,
    input  rvInstrPkg::tWord  loadWord,
    input  logic              loadLast,
    output logic              lineWrValid,
    output memPkg::tLineWrite lineWr,
    output logic              preloadDone
);
    import memPkg::*;

    // Next free slot in the line being built
    logic [$clog2(CL_WORDS)-1:0] slot;
    // Lines written so far, one extra bit for full
    logic [$bits(tLineAddr):0]   lineCnt;
    tCacheLine                   asmLine;
    tCacheLine                   nextLine;
    logic                        l2Full;
    logic                        accept;
    logic                        lastSeen;
    logic                        flush;

    // MSB set once every line has been written
    assign l2Full   = lineCnt[$bits(tLineAddr)];
    // Words after the last one or beyond L2 are dropped
    assign accept   = loadValid && !preloadDone && !l2Full;
    assign lastSeen = loadLast && !preloadDone;

    // Full line, or last word with anything pending
    assign flush = (accept && slot == '1) ||
                   (lastSeen && !l2Full && (accept || slot != '0));

    // Line with this cycle's word merged in
    always_comb begin
        nextLine = asmLine;
        if (accept) begin
            nextLine.w[slot] = loadWord;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            slot        <= '0;
            lineCnt     <= '0;
            lineWrValid <= 1'b0;
            preloadDone <= 1'b0;
            asmLine     <= FILLER_LINE;
        end else begin
            lineWrValid <= flush;
            if (flush) begin
                // Restart with a clean filler line
                slot    <= '0;
                lineCnt <= lineCnt + 1'b1;
                asmLine <= FILLER_LINE;
            end else if (accept) begin
                slot    <= slot + 1'b1;
                asmLine <= nextLine;
            end
            // Rises together with the final line write
            if (lastSeen) begin
                preloadDone <= 1'b1;
            end
        end
    end

    // Outgoing write, held until the next flush
    always_ff @(posedge clk) begin
        if (flush) begin
            lineWr.addr <= lineCnt[$bits(tLineAddr)-1:0];
            lineWr.line <= nextLine;
        end
    end

endmodule

//--- design/fetchUnit.sv
module fetchUnit (
    input  logic              clk,
    input  logic              rstN,
    input  logic              preloadDone,
    input  logic              redirectValid,
    input  rvInstrPkg::tWord  redirectPc,
    input  logic              haltReq,
    output logic              lineRdValid,
    output memPkg::tLineAddr  lineRdAddr,
    input  memPkg::tCacheLine lineRdData,
    output logic              instrValid,
    output rvInstrPkg::tWord  instr,
    output rvInstrPkg::tWord  instrPc
);
    import rvInstrPkg::*;
    import memPkg::*;

    typedef enum logic [2:0] {
        IDLE,
        REQ,
        FILL,
        RUN,
        STOP
    } tFetchState;

    tFetchState                  state;
    tFetchState                  nextState;
    tWord                        pc;
    tWord                        nextPc;
    // Single-line buffer and its tag
    tCacheLine                   lineBuf;
    tLineAddr                    tag;
    tLineAddr                    pcLine;
    logic [$clog2(CL_WORDS)-1:0] pcSlot;
    logic                        hit;

    assign pcLine = pc[LINE_IDX_LSB +: $bits(tLineAddr)];
    assign pcSlot = pc[WORD_IDX_LSB +: $clog2(CL_WORDS)];
    // RUN is only entered after a fill, so the tag is always loaded there
    assign hit    = (tag == pcLine);

    // Read request lasts exactly one cycle
    assign lineRdValid = (state == REQ);
    assign lineRdAddr  = pcLine;

    // Hit presents the word in the same cycle
    assign instrValid = (state == RUN) && hit;
    assign instr      = lineBuf.w[pcSlot];
    assign instrPc    = pc;

    always_comb begin
        nextState = state;
        nextPc    = pc;
        case (state)
            IDLE: begin
                if (preloadDone) begin
                    nextState = REQ;
                end
            end
            REQ: nextState = FILL;
            FILL: nextState = RUN;
            RUN: begin
                // Halt has priority over a redirect
                if (haltReq) begin
                    nextState = STOP;
                end else if (redirectValid) begin
                    // Tag of the new PC is checked next cycle
                    nextPc = redirectPc;
                end else if (hit) begin
                    nextPc = pc + 32'd4;
                end else begin
                    nextState = REQ;
                end
            end
            default: nextState = state;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= IDLE;
            pc    <= '0;
            tag   <= '0;
        end else begin
            state <= nextState;
            pc    <= nextPc;
            // Returning line belongs to the current PC
            if (state == FILL) begin
                tag <= pcLine;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == FILL) begin
            lineBuf <= lineRdData;
        end
    end

endmodule

//--- design/execCore.sv
module execCore (
    input  logic               clk,
    input  logic               rstN,
    input  logic               instrValid,
    input  rvInstrPkg::tWord   instr,
    input  rvInstrPkg::tWord   instrPc,
    output logic               redirectValid,
    output rvInstrPkg::tWord   redirectPc,
    output logic               haltReq,
    output logic               retireValid,
    output rvInstrPkg::tRetire retire,
    output logic               halted
);
    import rvInstrPkg::*;

    tWord       regFile [32];
    tOpcode     opcode;
    tRegIdx     rs1;
    tRegIdx     rs2;
    tRegIdx     rd;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       baseF7;
    logic       altF7;
    logic       f7Ok;
    tWord       immI;
    tWord       immB;
    tWord       srcA;
    tWord       srcB;
    tWord       aluB;
    tWord       aluRes;
    tAluOp      aluOp;
    logic       isAlu;
    logic       isBranch;
    logic       isEbreak;
    logic       brTaken;
    tRetire     retNext;

    // Instruction fields
    assign opcode = tOpcode'(instr[6:0]);
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign funct7 = instr[31:25];
    assign baseF7 = (funct7 == F7_BASE);
    assign altF7  = (funct7 == F7_ALT);
    // ALT form only exists for SUB and SRA/SRAI
    assign f7Ok   = baseF7 || (altF7 && (funct3 inside {F3_ADD_SUB, F3_SRL_SRA}));

    // Sign-extended immediates
    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immB = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};

    // x0 always reads zero
    assign srcA = (rs1 == '0) ? '0 : regFile[rs1];
    assign srcB = (rs2 == '0) ? '0 : regFile[rs2];
    assign aluB = (opcode == OP) ? srcB : immI;

    // Supported encodings only, others retire with wen low
    assign isAlu = ((opcode == OP) && f7Ok &&
                    (funct3 inside {F3_ADD_SUB, F3_SLL, F3_SLT, F3_SLTU, F3_XOR, F3_SRL_SRA})) ||
                   ((opcode == OP_IMM) &&
                    ((funct3 inside {F3_ADD_SUB, F3_XOR}) ||
                     (f7Ok && (funct3 inside {F3_SLL, F3_SRL_SRA})))); 
    assign isBranch = (opcode == BRANCH) && (funct3 inside {F3_BEQ, F3_BNE});
    assign isEbreak = (opcode == SYSTEM) && (instr == EBREAK_INSTR);

    // funct3 to ALU op, SUB only in register form
    always_comb begin
        case (funct3)
            F3_ADD_SUB: aluOp = (opcode == OP && altF7) ? SUB : ADD;
            F3_SLL:     aluOp = SLL;
            F3_SLT:     aluOp = SLT;
            F3_SLTU:    aluOp = SLTU;
            F3_XOR:     aluOp = XOR;
            F3_SRL_SRA: aluOp = altF7 ? SRA : SRL;
            default:    aluOp = ADD;
        endcase
    end

    always_comb begin
        case (aluOp)
            ADD:     aluRes = srcA + aluB;
            SUB:     aluRes = srcA - aluB;
            XOR:     aluRes = srcA ^ aluB;
            SLT:     aluRes = {31'b0, $signed(srcA) < $signed(aluB)};
            SLTU:    aluRes = {31'b0, srcA < aluB};
            SLL:     aluRes = srcA << aluB[4:0];
            SRL:     aluRes = srcA >> aluB[4:0];
            SRA:     aluRes = $unsigned($signed(srcA) >>> aluB[4:0]);
            default: aluRes = srcA + aluB;
        endcase
    end

    // Branch resolves in the execute cycle
    assign brTaken       = isBranch && ((funct3 == F3_BEQ) ? (srcA == srcB) : (srcA != srcB));
    assign redirectValid = instrValid && brTaken;
    assign redirectPc    = instrPc + immB;
    assign haltReq       = instrValid && isEbreak;

    // Write to x0 retires without a write
    always_comb begin
        retNext.rd   = rd;
        retNext.wen  = isAlu && (rd != '0);
        retNext.data = retNext.wen ? aluRes : '0;
        retNext.pc   = instrPc;
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            retireValid <= 1'b0;
            halted      <= 1'b0;
            for (int i = 0; i < 32; i++) begin
                regFile[i] <= '0;
            end
        end else begin
            retireValid <= instrValid;
            // Sticky until reset
            if (haltReq) begin
                halted <= 1'b1;
            end
            if (instrValid && retNext.wen) begin
                regFile[rd] <= aluRes;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (instrValid) begin
            retire <= retNext;
        end
    end

endmodule

//--- design/vroomTop.sv
module vroomTop (
    input  logic               clk,
    input  logic               rstN,
    input  logic               loadValid,
    input  rvInstrPkg::tWord   loadWord,
    input  logic               loadLast,
    output logic               retireValid,
    output rvInstrPkg::tRetire retire,
    output logic               halted
);
    import rvInstrPkg::*;
    import memPkg::*;

    // Loader to L2
    logic      lineWrValid;
    tLineWrite lineWr;
    logic      preloadDone;

    // L2 to fetch
    logic      lineRdValid;
    tLineAddr  lineRdAddr;
    tCacheLine lineRdData;

    // Fetch and core
    logic      instrValid;
    tWord      instr;
    tWord      instrPc;
    logic      redirectValid;
    tWord      redirectPc;
    logic      haltReq;

    preload uPreload (
        .clk,
        .rstN,
        .loadValid,
        .loadWord,
        .loadLast,
        .lineWrValid,
        .lineWr,
        .preloadDone
    );

    l2Mem uL2 (
        .clk,
        .rstN,
        .lineWrValid,
        .lineWr,
        .lineRdValid,
        .lineRdAddr,
        .lineRdData
    );

    fetchUnit uFetch (
        .clk,
        .rstN,
        .preloadDone,
        .redirectValid,
        .redirectPc,
        .haltReq,
        .lineRdValid,
        .lineRdAddr,
        .lineRdData,
        .instrValid,
        .instr,
        .instrPc
    );

    execCore uCore (
        .clk,
        .rstN,
        .instrValid,
        .instr,
        .instrPc,
        .redirectValid,
        .redirectPc,
        .haltReq,
        .retireValid,
        .retire,
        .halted
    );

endmodule

//--- testbench/tbTop_assert.sv
module vroomTopAssert (
    input logic               clk,
    input logic               rstN,
    input logic               preloadDone,
    input logic               retireValid,
    input rvInstrPkg::tRetire retire,
    input logic               halted
);
    timeunit 1ns;
    timeprecision 1ps;

    // Core only runs once L2 holds the program
    retireAfterLoad: assert property (@(posedge clk) disable iff (!rstN)
        retireValid |-> preloadDone)
        else $error("retireValid seen before preloadDone");

    // x0 never shows up as a written register
    wenNeedsRd: assert property (@(posedge clk) disable iff (!rstN)
        (retireValid && retire.wen) |-> (retire.rd != 5'd0))
        else $error("retire.wen set with rd equal to x0");

    // EBREAK retire and halted coincide, nothing follows
    quietAfterHalt: assert property (@(posedge clk) disable iff (!rstN)
        halted |=> !retireValid)
        else $error("retireValid seen after halted");

    // Sticky halt
    haltSticky: assert property (@(posedge clk) disable iff (!rstN)
        halted |=> halted)
        else $error("halted dropped without reset");

endmodule

bind vroomTop vroomTopAssert uAssert (
    .clk,
    .rstN,
    .preloadDone,
    .retireValid,
    .retire,
    .halted
);

//--- testbench/tbTop.sv
module tbTop;
    timeunit 1ns;
    timeprecision 1ps;

    import rvInstrPkg::*;

    localparam int CLK_HALF          = 4;
    localparam int RESET_CYCLES      = 8;
    localparam int MAX_GAP           = 3;
    localparam int QUIET_CYCLES      = 50;
    localparam int CYCLES_PER_RETIRE = 20;
    localparam int FILE_WORDS        = 256;
    localparam int MAX_PROGRAM       = 128;
    // Byte address where the second cache line starts
    localparam logic [31:0] LINE1_PC = 32'h40;

    // Result groups, one line each in the summary
    localparam int KIND_PAD    = 0;
    localparam int KIND_ALU    = 1;
    localparam int KIND_X0     = 2;
    localparam int KIND_BRANCH = 3;
    localparam int KIND_CROSS  = 4;
    localparam int KIND_HALT   = 5;

    logic        clk;
    logic        rstN;
    logic        loadValid;
    tWord        loadWord;
    logic        loadLast;
    logic        retireValid;
    tRetire      retire;
    logic        halted;

    // Data file image and its layout
    logic [31:0] fileMem [FILE_WORDS];
    int          wordCount;
    int          expCount;
    int          recBase;

    int          errs [6] = '{default: 0};
    int          retIdx = 0;
    logic        haltedPrev = 1'b0;
    int          cycles = 0;
    int          cycleLimit = 1000000;
    integer      seed;

    vroomTop dut (
        .clk,
        .rstN,
        .loadValid,
        .loadWord,
        .loadLast,
        .retireValid,
        .retire,
        .halted
    );

    always #CLK_HALF clk = ~clk;

    // Hang guard
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycleLimit) begin
            $display("Timeout: core did not finish within %0d cycles", cycleLimit);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] programWord(input logic [31:0] pc);
        int slot;
        slot = int'(pc >> 2);
        if (slot < wordCount) begin
            return fileMem[1 + slot];
        end
        return 32'h0;
    endfunction

    // Group a record by the instruction at its pc
    function automatic int recordKind(input logic [31:0] word);
        int kind;
        case (word[6:0])
            7'h63:   kind = KIND_BRANCH;
            7'h73:   kind = KIND_HALT;
            default: kind = (word[11:7] == 5'd0) ? KIND_X0 : KIND_ALU;
        endcase
        return kind;
    endfunction

    function automatic string kindName(input int kind);
        case (kind)
            KIND_PAD:    return "preload padding";
            KIND_ALU:    return "ALU results";
            KIND_X0:     return "register x0";
            KIND_BRANCH: return "branches";
            KIND_CROSS:  return "line crossing";
            default:     return "halt";
        endcase
    endfunction

    task automatic checkRetire(input int idx);
        logic [31:0] expPc;
        logic [31:0] expRd;
        logic [31:0] expWen;
        logic [31:0] expData;
        int          kind;
        int          bad;
        expPc   = fileMem[recBase + 1 + 4 * idx];
        expRd   = fileMem[recBase + 2 + 4 * idx];
        expWen  = fileMem[recBase + 3 + 4 * idx];
        expData = fileMem[recBase + 4 + 4 * idx];
        kind    = recordKind(programWord(expPc));
        bad     = 0;
        // pc order covers branch targets and loop count
        if (retire.pc !== expPc) begin
            $display("Mismatch retire.pc at record %0d: got %h expected %h",
                     idx, retire.pc, expPc);
            bad++;
        end
        if (retire.wen !== expWen[0]) begin
            $display("Mismatch retire.wen at record %0d: got %h expected %h",
                     idx, retire.wen, expWen[0]);
            bad++;
        end
        // rd and data only mean something with wen set
        if (expWen[0]) begin
            if (retire.rd !== expRd[4:0]) begin
                $display("Mismatch retire.rd at record %0d: got %h expected %h",
                         idx, retire.rd, expRd[4:0]);
                bad++;
            end
            if (retire.data !== expData) begin
                $display("Mismatch retire.data at record %0d: got %h expected %h",
                         idx, retire.data, expData);
                bad++;
            end
        end
        // Filler slots sit past the last program word
        if (retire.pc >= 32'(4 * wordCount)) begin
            $display("Error: filler slot at pc %h was executed", retire.pc);
            errs[KIND_PAD]++;
        end
        if (kind == KIND_HALT && halted !== 1'b1) begin
            $display("Error: halted is low at the EBREAK retire");
            bad++;
        end
        if (kind != KIND_HALT && halted !== 1'b0) begin
            $display("Error: halted is high before EBREAK retired");
            bad++;
        end
        errs[kind] += bad;
        if (expPc >= LINE1_PC) begin
            errs[KIND_CROSS] += bad;
        end
    endtask

    // Outputs move on posedge, sampled here
    always @(negedge clk) begin
        if (rstN) begin
            if (halted && !haltedPrev && !retireValid) begin
                $display("Error: halted rose without a retire");
                errs[KIND_HALT]++;
            end
            if (retireValid) begin
                if (haltedPrev) begin
                    $display("Error: retire at pc %h after the core halted", retire.pc);
                    errs[KIND_HALT]++;
                end else if (retIdx >= expCount) begin
                    $display("Error: retire at pc %h beyond the expected records", retire.pc);
                    errs[KIND_PAD]++;
                end else begin
                    checkRetire(retIdx);
                end
                retIdx++;
            end
            haltedPrev = halted;
        end
    end

    initial begin
        int gap;
        int countErr;
        int errTotal;
        clk       = 1'b0;
        rstN      = 1'b0;
        loadValid = 1'b0;
        loadWord  = '0;
        loadLast  = 1'b0;
        seed      = 32'h9ea1ce9d;
        countErr  = 0;
        errTotal  = 0;

        $readmemh("testbench/programInput.hex", fileMem);
        wordCount = fileMem[0];
        recBase   = 1 + wordCount;
        if (wordCount <= 0 || wordCount > MAX_PROGRAM) begin
            $display("Error: data file holds no usable program length");
            $display("RESULT: FAIL");
            $finish;
        end
        expCount   = fileMem[recBase];
        // Reset, worst-case stream, retires, quiet window
        cycleLimit = RESET_CYCLES + (MAX_GAP + 1) * wordCount +
                     CYCLES_PER_RETIRE * expCount + QUIET_CYCLES;

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;

        // Random idle gaps between words
        for (int i = 0; i < wordCount; i++) begin
            gap = $random(seed) & MAX_GAP;
            repeat (gap) @(negedge clk);
            loadValid = 1'b1;
            loadWord  = fileMem[1 + i];
            loadLast  = (i == wordCount - 1);
            @(negedge clk);
            loadValid = 1'b0;
            loadLast  = 1'b0;
        end
        $display("Test preload stream: %0d words sent", wordCount);

        while (!halted) @(negedge clk);
        repeat (QUIET_CYCLES) @(negedge clk);

        if (retIdx != expCount) begin
            $display("Error: %0d retires seen, data file expects %0d", retIdx, expCount);
            countErr = 1;
        end

        for (int k = 0; k < 6; k++) begin
            if (k == KIND_BRANCH) begin
                $display("Test %s: %s, %0d errors", kindName(k),
                         (errs[k] + countErr == 0) ? "ok" : "FAILED", errs[k] + countErr);
            end else begin
                $display("Test %s: %s, %0d errors", kindName(k),
                         (errs[k] == 0) ? "ok" : "FAILED", errs[k]);
            end
            // Crossing errors are already counted in their own group
            if (k != KIND_CROSS) begin
                errTotal += errs[k];
            end
        end
        errTotal += countErr;

        $display("Totals: %0d of %0d retires seen, %0d errors", retIdx, expCount, errTotal);
        if (errTotal == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- sim.f
design/rvInstrPkg.sv
design/memPkg.sv
design/l2Mem.sv
design/preload.sv
design/fetchUnit.sv
design/execCore.sv
design/vroomTop.sv
testbench/tbTop_assert.sv
testbench/tbTop.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := tbTop
FILELIST  := sim.f

OBJDIR    := obj_dir
BIN       := $(OBJDIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(shell grep -v '^+' $(FILELIST))
DATA      := testbench/programInput.hex

.PHONY: all run clean

all: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR) -o V$(TOP)

run: $(BIN) $(DATA)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@! grep -q "RESULT: FAIL" $(LOG) && grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- testbench/programInput.hex
// Word 0 is the program length, then one program word per line
// Then the expected retire count, then records of pc rd wen data
00000014
00400093 // 00 addi x1, x0, 4
00000113 // 04 addi x2, x0, 0
00300193 // 08 addi x3, x0, 3
00310133 // 0c add  x2, x2, x3
fff08093 // 10 addi x1, x1, -1
fe009ce3 // 14 bne  x1, x0, 0x0c
40310233 // 18 sub  x4, x2, x3
003242b3 // 1c xor  x5, x4, x3
fff2c313 // 20 xori x6, x5, -1
00419393 // 24 slli x7, x3, 4
01c35413 // 28 srli x8, x6, 28
41c35493 // 2c srai x9, x6, 28
00332533 // 30 slt  x10, x6, x3
003335b3 // 34 sltu x11, x6, x3
00500013 // 38 addi x0, x0, 5
00300633 // 3c add  x12, x0, x3
00360463 // 40 beq  x12, x3, 0x48
00100693 // 44 addi x13, x0, 1
00300463 // 48 beq  x0, x3, 0x50
00100073 // 4c ebreak
0000001c
00000000 01 1 00000004
00000004 02 1 00000000
00000008 03 1 00000003
0000000c 02 1 00000003
00000010 01 1 00000003
00000014 00 0 00000000
0000000c 02 1 00000006
00000010 01 1 00000002
00000014 00 0 00000000
0000000c 02 1 00000009
00000010 01 1 00000001
00000014 00 0 00000000
0000000c 02 1 0000000c
00000010 01 1 00000000
00000014 00 0 00000000
00000018 04 1 00000009
0000001c 05 1 0000000a
00000020 06 1 fffffff5
00000024 07 1 00000030
00000028 08 1 0000000f
0000002c 09 1 ffffffff
00000030 0a 1 00000001
00000034 0b 1 00000000
00000038 00 0 00000000
0000003c 0c 1 00000003
00000040 00 0 00000000
00000048 00 0 00000000
0000004c 00 0 00000000
